// File: arp_proto_pkg.sv
// =====================================
// ARP and Ethernet protocol definitions
// shared by the decode, resolve and
// frame build stages of the ARP engine
// =====================================

package arp_proto_pkg;

    // ethernet and ARP header constants
    localparam logic [15:0] ETH_TYPE_ARP     = 16'h0806;
    localparam logic [15:0] ARP_HTYPE_ETH    = 16'h0001;
    localparam logic [15:0] ARP_PTYPE_IPV4   = 16'h0800;
    localparam logic [15:0] ARP_OPER_REQUEST = 16'h0001;
    localparam logic [15:0] ARP_OPER_REPLY   = 16'h0002;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;

    localparam mac_t MAC_BCAST = 48'hffff_ffff_ffff;

    // one parsed ARP frame, ethernet header included
    typedef struct packed {
        mac_t        eth_dest;
        mac_t        eth_src;
        logic [15:0] eth_type;
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [15:0] oper;
        mac_t        sha;
        ip_t         spa;
        mac_t        tha;
        ip_t         tpa;
    } arp_frame_t;

endpackage

// File: arp_engine_pkg.sv
// =====================================
// ARP engine configuration, timers and
// the structs passed between its stages
// =====================================

package arp_engine_pkg;

    // request retries, counted in clock cycles
    localparam int RETRY_COUNT     = 4;
    localparam int RETRY_INTERVAL  = 200;
    localparam int REQUEST_TIMEOUT = 600;
    localparam int RETRY_W         = $clog2(RETRY_COUNT + 1);
    localparam int TIMER_W         = $clog2(REQUEST_TIMEOUT + 1);

    // direct-mapped cache geometry
    localparam int CACHE_ADDR_W = 4;
    localparam int CACHE_DEPTH  = 1 << CACHE_ADDR_W;

    typedef struct packed {
        arp_proto_pkg::mac_t local_mac;
        arp_proto_pkg::ip_t  local_ip;
        arp_proto_pkg::ip_t  gateway_ip;
        arp_proto_pkg::ip_t  subnet_mask;
    } net_cfg_t;

    typedef struct packed {
        arp_proto_pkg::ip_t  ip;
        arp_proto_pkg::mac_t mac;
    } cache_wr_t;

    typedef struct packed {
        logic                error;
        arp_proto_pkg::mac_t mac;
    } lookup_resp_t;

    // what a reply needs to know about the peer
    typedef struct packed {
        arp_proto_pkg::mac_t eth_src;
        arp_proto_pkg::mac_t sha;
        arp_proto_pkg::ip_t  spa;
    } reply_req_t;

endpackage

// File: arp_hold_reg.sv
// =====================================
// one-entry valid/ready holding register
// for any packed payload, set through
// the payload_t type parameter
// =====================================
`timescale 1ns/10ps

module arp_hold_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // free when empty or drained in this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
        if (in_ready && in_valid) begin
            out_data <= in_data;
        end
    end

    held_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: arp_cache.sv
// =====================================
// direct-mapped IP to MAC table; answers
// a query one cycle later with hit or
// miss, learns on write, clears on cmd
// =====================================
`timescale 1ns/10ps

module arp_cache (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      query_valid,
    input  arp_proto_pkg::ip_t        query_ip,
    output logic                      hit_valid,
    output logic                      miss,
    output arp_proto_pkg::mac_t       hit_mac,
    input  arp_engine_pkg::cache_wr_t cache_wr,
    input  logic                      cache_wr_valid,
    input  logic                      clear_cache
);
    import arp_proto_pkg::*;
    import arp_engine_pkg::*;

    logic [CACHE_DEPTH-1:0]  entry_valid;
    ip_t                     tag_mem [CACHE_DEPTH];
    mac_t                    mac_mem [CACHE_DEPTH];
    logic [CACHE_ADDR_W-1:0] wr_idx;
    logic [CACHE_ADDR_W-1:0] rd_idx;
    logic                    rd_match;

    // index is the low bits of the IP, full IP kept as tag
    assign wr_idx   = cache_wr.ip[CACHE_ADDR_W-1:0];
    assign rd_idx   = query_ip[CACHE_ADDR_W-1:0];
    assign rd_match = entry_valid[rd_idx] && (tag_mem[rd_idx] == query_ip);

    // clear drops every entry and wins over a write
    always_ff @(posedge clk) begin
        if (rst || clear_cache) begin
            entry_valid <= '0;
        end else if (cache_wr_valid) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cache_wr_valid) begin
            tag_mem[wr_idx] <= cache_wr.ip;
            mac_mem[wr_idx] <= cache_wr.mac;
        end
    end

    // registered lookup result
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_valid <= 1'b0;
            miss      <= 1'b0;
        end else begin
            hit_valid <= query_valid && rd_match;
            miss      <= query_valid && !rd_match;
        end
        hit_mac <= mac_mem[rd_idx];
    end

endmodule

// File: arp_rx_decode.sv
// =====================================
// checks incoming ARP frames, learns
// the sender into the cache and raises
// a reply intent for requests to us
// =====================================
`timescale 1ns/10ps

module arp_rx_decode (
    input  logic                       clk,
    input  logic                       rst,
    input  arp_engine_pkg::net_cfg_t   cfg,
    input  arp_proto_pkg::arp_frame_t  in_frame,
    input  logic                       in_valid,
    input  logic                       reply_ready,
    output arp_engine_pkg::cache_wr_t  cache_wr,
    output logic                       cache_wr_valid,
    output arp_engine_pkg::reply_req_t reply,
    output logic                       reply_valid
);
    import arp_proto_pkg::*;

    logic accept;
    logic frame_ok;
    logic for_us;

    // frames only move when the output side can take a reply
    assign accept = in_valid && reply_ready;

    assign frame_ok = (in_frame.eth_type == ETH_TYPE_ARP)
                   && (in_frame.htype == ARP_HTYPE_ETH)
                   && (in_frame.ptype == ARP_PTYPE_IPV4);

    assign for_us = frame_ok && (in_frame.oper == ARP_OPER_REQUEST)
                 && (in_frame.tpa == cfg.local_ip);

    // reply intent rides on the input handshake, tx side registers it
    assign reply_valid   = in_valid && for_us;
    assign reply.eth_src = in_frame.eth_src;
    assign reply.sha     = in_frame.sha;
    assign reply.spa     = in_frame.spa;

    // learn sender of every good frame
    always_ff @(posedge clk) begin
        if (rst) begin
            cache_wr_valid <= 1'b0;
        end else begin
            cache_wr_valid <= accept && frame_ok;
        end
        if (accept) begin
            cache_wr.ip  <= in_frame.spa;
            cache_wr.mac <= in_frame.sha;
        end
    end

endmodule

// File: arp_resolver.sv
// =====================================
// lookup side of the ARP engine: picks
// broadcast, subnet or gateway target,
// queries the cache and on a miss sends
// request probes until hit or timeout
// =====================================
`timescale 1ns/10ps

module arp_resolver (
    input  logic                         clk,
    input  logic                         rst,
    input  arp_engine_pkg::net_cfg_t     cfg,
    input  arp_proto_pkg::ip_t           req_ip,
    input  logic                         req_valid,
    output logic                         req_ready,
    output arp_engine_pkg::lookup_resp_t resp,
    output logic                         resp_valid,
    input  logic                         resp_ready,
    output logic                         query_valid,
    output arp_proto_pkg::ip_t           query_ip,
    input  logic                         hit_valid,
    input  logic                         miss,
    input  arp_proto_pkg::mac_t          hit_mac,
    output logic                         probe,
    output arp_proto_pkg::ip_t           probe_ip
);
    import arp_proto_pkg::*;
    import arp_engine_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_QUERY, ST_RESOLVE} state_t;

    state_t             state, state_next;
    ip_t                target_ip, target_next;
    logic [RETRY_W-1:0] retry_cnt, retry_next;
    logic [TIMER_W-1:0] timer, timer_next;
    logic               query_next;
    logic               probe_next;
    logic               resp_push;
    lookup_resp_t       resp_data;
    logic               resp_in_ready;
    logic               in_subnet;
    logic               is_bcast;

    // no bits differ from the gateway where the mask is set
    assign in_subnet = ((req_ip ^ cfg.gateway_ip) & cfg.subnet_mask) == '0;
    // limited broadcast, or all host bits set inside our subnet
    assign is_bcast  = (req_ip == '1) || (in_subnet && ((req_ip | cfg.subnet_mask) == '1));

    assign query_ip = target_ip;
    assign probe_ip = target_ip;

    always_comb begin
        state_next  = state;
        target_next = target_ip;
        retry_next  = retry_cnt;
        timer_next  = timer;
        query_next  = 1'b0;
        probe_next  = 1'b0;
        resp_push   = 1'b0;
        resp_data   = '{error: 1'b0, mac: MAC_BCAST};
        case (state)
            ST_IDLE: begin
                if (req_valid && req_ready) begin
                    if (is_bcast) begin
                        resp_push = 1'b1;
                    end else begin
                        target_next = in_subnet ? req_ip : cfg.gateway_ip;
                        query_next  = 1'b1;
                        state_next  = ST_QUERY;
                    end
                end
            end
            ST_QUERY: begin
                query_next = 1'b1;
                if (hit_valid) begin
                    resp_push     = 1'b1;
                    resp_data.mac = hit_mac;
                    query_next    = 1'b0;
                    state_next    = ST_IDLE;
                end else if (miss) begin
                    // first probe right away
                    probe_next = 1'b1;
                    retry_next = RETRY_W'(RETRY_COUNT - 1);
                    timer_next = TIMER_W'(RETRY_INTERVAL - 1);
                    state_next = ST_RESOLVE;
                end
            end
            default: begin
                // keep polling, a reply lands in the cache
                query_next = 1'b1;
                timer_next = timer - 1'b1;
                if (hit_valid) begin
                    resp_push     = 1'b1;
                    resp_data.mac = hit_mac;
                    query_next    = 1'b0;
                    state_next    = ST_IDLE;
                end else if (timer == '0) begin
                    if (retry_cnt != '0) begin
                        probe_next = 1'b1;
                        retry_next = retry_cnt - 1'b1;
                        timer_next = (retry_cnt > 1) ? TIMER_W'(RETRY_INTERVAL - 1)
                                                     : TIMER_W'(REQUEST_TIMEOUT - 1);
                    end else begin
                        resp_push  = 1'b1;
                        resp_data  = '{error: 1'b1, mac: '0};
                        query_next = 1'b0;
                        state_next = ST_IDLE;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            retry_cnt   <= '0;
            timer       <= '0;
            query_valid <= 1'b0;
            probe       <= 1'b0;
            req_ready   <= 1'b0;
        end else begin
            state       <= state_next;
            retry_cnt   <= retry_next;
            timer       <= timer_next;
            query_valid <= query_next;
            probe       <= probe_next;
            // only take a new lookup once the response has left
            req_ready   <= (state_next == ST_IDLE) && !resp_push && !(resp_valid && !resp_ready);
        end
        target_ip <= target_next;
    end

    arp_hold_reg #(
        .payload_t(lookup_resp_t)
    ) resp_hold_inst (
        .clk      (clk),
        .rst      (rst),
        .in_data  (resp_data),
        .in_valid (resp_push),
        .in_ready (resp_in_ready),
        .out_data (resp),
        .out_valid(resp_valid),
        .out_ready(resp_ready)
    );

    no_ready_while_resp: assert property (@(posedge clk) disable iff (rst)
        !(req_ready && resp_valid));

    push_not_dropped: assert property (@(posedge clk) disable iff (rst)
        resp_push |-> resp_in_ready);

endmodule

// File: arp_tx_build.sv
// =====================================
// builds ARP reply and request frames
// and feeds them to the outgoing frame
// register, probes before replies
// =====================================
`timescale 1ns/10ps

module arp_tx_build (
    input  logic                       clk,
    input  logic                       rst,
    input  arp_engine_pkg::net_cfg_t   cfg,
    input  arp_engine_pkg::reply_req_t reply,
    input  logic                       reply_valid,
    output logic                       reply_ready,
    input  logic                       probe,
    input  arp_proto_pkg::ip_t         probe_ip,
    output arp_proto_pkg::arp_frame_t  out_frame,
    output logic                       out_valid,
    input  logic                       out_ready
);
    import arp_proto_pkg::*;

    logic       probe_pend;
    ip_t        probe_ip_q;
    logic       probe_go;
    logic       hold_in_ready;
    arp_frame_t frame;

    assign probe_go    = probe || probe_pend;
    assign reply_ready = hold_in_ready && !probe_go;

    // probe waits here while the register is full
    always_ff @(posedge clk) begin
        if (rst) begin
            probe_pend <= 1'b0;
        end else if (hold_in_ready) begin
            probe_pend <= 1'b0;
        end else if (probe) begin
            probe_pend <= 1'b1;
        end
        if (probe) begin
            probe_ip_q <= probe_ip;
        end
    end

    always_comb begin
        frame.eth_src  = cfg.local_mac;
        frame.eth_type = ETH_TYPE_ARP;
        frame.htype    = ARP_HTYPE_ETH;
        frame.ptype    = ARP_PTYPE_IPV4;
        frame.sha      = cfg.local_mac;
        frame.spa      = cfg.local_ip;
        if (probe_go) begin
            // broadcast request for the target IP
            frame.eth_dest = MAC_BCAST;
            frame.oper     = ARP_OPER_REQUEST;
            frame.tha      = '0;
            frame.tpa      = probe ? probe_ip : probe_ip_q;
        end else begin
            frame.eth_dest = reply.eth_src;
            frame.oper     = ARP_OPER_REPLY;
            frame.tha      = reply.sha;
            frame.tpa      = reply.spa;
        end
    end

    arp_hold_reg #(
        .payload_t(arp_frame_t)
    ) frame_hold_inst (
        .clk      (clk),
        .rst      (rst),
        .in_data  (frame),
        .in_valid (probe_go || reply_valid),
        .in_ready (hold_in_ready),
        .out_data (out_frame),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// File: arp_top.sv
// =====================================
// ARP engine top level: frame decode,
// cache, lookup resolver, frame build
// =====================================
`timescale 1ns/10ps

module arp_top (
    input  logic                         clk,
    input  logic                         rst,
    input  arp_proto_pkg::arp_frame_t    in_frame,
    input  logic                         in_valid,
    output logic                         in_ready,
    output arp_proto_pkg::arp_frame_t    out_frame,
    output logic                         out_valid,
    input  logic                         out_ready,
    input  arp_proto_pkg::ip_t           req_ip,
    input  logic                         req_valid,
    output logic                         req_ready,
    output arp_engine_pkg::lookup_resp_t resp,
    output logic                         resp_valid,
    input  logic                         resp_ready,
    input  arp_engine_pkg::net_cfg_t     cfg,
    input  logic                         clear_cache
);
    import arp_proto_pkg::*;
    import arp_engine_pkg::*;

    cache_wr_t  cache_wr;
    logic       cache_wr_valid;
    reply_req_t reply;
    logic       reply_valid;
    logic       query_valid;
    ip_t        query_ip;
    logic       hit_valid;
    logic       miss;
    mac_t       hit_mac;
    logic       probe;
    ip_t        probe_ip;

    // in_ready is the tx side's reply_ready
    arp_rx_decode arp_rx_decode_inst (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg),
        .in_frame      (in_frame),
        .in_valid      (in_valid),
        .reply_ready   (in_ready),
        .cache_wr      (cache_wr),
        .cache_wr_valid(cache_wr_valid),
        .reply         (reply),
        .reply_valid   (reply_valid)
    );

    arp_cache arp_cache_inst (
        .clk           (clk),
        .rst           (rst),
        .query_valid   (query_valid),
        .query_ip      (query_ip),
        .hit_valid     (hit_valid),
        .miss          (miss),
        .hit_mac       (hit_mac),
        .cache_wr      (cache_wr),
        .cache_wr_valid(cache_wr_valid),
        .clear_cache   (clear_cache)
    );

    arp_resolver arp_resolver_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .req_ip     (req_ip),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .query_valid(query_valid),
        .query_ip   (query_ip),
        .hit_valid  (hit_valid),
        .miss       (miss),
        .hit_mac    (hit_mac),
        .probe      (probe),
        .probe_ip   (probe_ip)
    );

    arp_tx_build arp_tx_build_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .reply      (reply),
        .reply_valid(reply_valid),
        .reply_ready(in_ready),
        .probe      (probe),
        .probe_ip   (probe_ip),
        .out_frame  (out_frame),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

// File: tb_clk_gen.sv
// ========================================
// testbench clock and reset source; reset
// is high for the first few cycles and
// drops on a falling edge
// ========================================
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tb_arp.sv
// ========================================
// directed testbench for the ARP engine;
// drives frames and lookups on the falling
// edge and checks replies, probes and
// lookup responses against expected values
// ========================================
`timescale 1ns/10ps

module tb_arp;
    import arp_proto_pkg::*;
    import arp_engine_pkg::*;

    localparam int HS_TIMEOUT      = 50;
    localparam int RESP_TIMEOUT    = 100;
    localparam int QUIET_CYCLES    = 30;
    localparam int RESET_TIMEOUT   = 20;
    localparam int RESOLVE_TIMEOUT = RETRY_COUNT * RETRY_INTERVAL + REQUEST_TIMEOUT + 200;

    logic         clk;
    logic         rst;
    arp_frame_t   in_frame;
    logic         in_valid;
    logic         in_ready;
    arp_frame_t   out_frame;
    logic         out_valid;
    logic         out_ready;
    ip_t          req_ip;
    logic         req_valid;
    logic         req_ready;
    lookup_resp_t resp;
    logic         resp_valid;
    logic         resp_ready;
    net_cfg_t     cfg;
    logic         clear_cache;

    arp_frame_t   out_q[$];
    lookup_resp_t resp_q[$];
    logic [31:0]  rng_state;
    int           errors;
    int           tests_run;
    int           tests_failed;
    mac_t         peer_a_mac;
    ip_t          peer_a_ip;

    tb_clk_gen #(.PERIOD(40), .RESET_CYCLES(4)) clk_gen_inst (.clk(clk), .rst(rst));

    arp_top UUT (
        .clk        (clk),
        .rst        (rst),
        .in_frame   (in_frame),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_frame  (out_frame),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .req_ip     (req_ip),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .cfg        (cfg),
        .clear_cache(clear_cache)
    );

    // record every completed output transfer, sampled mid low phase
    always @(negedge clk) begin
        #2;
        if (!rst && out_valid && out_ready) begin
            out_q.push_back(out_frame);
        end
        if (!rst && resp_valid && resp_ready) begin
            resp_q.push_back(resp);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // peer inside the subnet, host byte ends in 5 so it never hits local or gateway
    task automatic draw_peer(output mac_t mac, output ip_t ip);
        logic [31:0] r1;
        logic [31:0] r2;
        rng_state = xorshift32(rng_state);
        r1 = rng_state;
        rng_state = xorshift32(rng_state);
        r2 = rng_state;
        mac = {8'h02, r1[7:0], r2};
        ip  = {24'hc0_a8_01, r1[15:12], 4'h5};
    endtask

    function automatic arp_frame_t make_in_frame(input logic [15:0] oper,
                                                 input logic [15:0] eth_type,
                                                 input mac_t mac, input ip_t spa,
                                                 input ip_t tpa);
        arp_frame_t f;
        f.eth_dest = MAC_BCAST;
        f.eth_src  = mac;
        f.eth_type = eth_type;
        f.htype    = ARP_HTYPE_ETH;
        f.ptype    = ARP_PTYPE_IPV4;
        f.oper     = oper;
        f.sha      = mac;
        f.spa      = spa;
        f.tha      = '0;
        f.tpa      = tpa;
        return f;
    endfunction

    function automatic arp_frame_t make_reply_exp(input mac_t mac, input ip_t ip);
        arp_frame_t f;
        f = make_in_frame(ARP_OPER_REPLY, ETH_TYPE_ARP, cfg.local_mac, cfg.local_ip, ip);
        f.eth_dest = mac;
        f.tha      = mac;
        return f;
    endfunction

    function automatic arp_frame_t make_request_exp(input ip_t ip);
        return make_in_frame(ARP_OPER_REQUEST, ETH_TYPE_ARP, cfg.local_mac, cfg.local_ip, ip);
    endfunction

    task automatic compare_frame(input string name, input arp_frame_t got, input arp_frame_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_resp(input string name, input lookup_resp_t got,
                                input lookup_resp_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_frame(input arp_frame_t f);
        int  n;
        logic done;
        in_frame = f;
        in_valid = 1'b1;
        done = 1'b0;
        for (n = 0; n < HS_TIMEOUT && !done; n++) begin
            #1;
            done = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
        if (!done) begin
            $display("input frame was not accepted within %0d cycles", HS_TIMEOUT);
            errors++;
        end
    endtask

    task automatic send_lookup(input ip_t ip);
        int  n;
        logic done;
        req_ip = ip;
        req_valid = 1'b1;
        done = 1'b0;
        for (n = 0; n < HS_TIMEOUT && !done; n++) begin
            #1;
            done = req_ready;
            @(negedge clk);
        end
        req_valid = 1'b0;
        if (!done) begin
            $display("lookup request for %h was not accepted", ip);
            errors++;
        end
    endtask

    task automatic wait_frames(input int count, input int limit, input string what);
        int n;
        n = 0;
        while (out_q.size() < count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (out_q.size() < count) begin
            $display("timed out waiting for %s", what);
            errors++;
        end
    endtask

    task automatic lookup_check(input ip_t ip, input int limit, input lookup_resp_t exp);
        int n;
        resp_q.delete();
        send_lookup(ip);
        n = 0;
        while (resp_q.size() == 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (resp_q.size() == 0) begin
            $display("no lookup response for %h within %0d cycles", ip, limit);
            errors++;
        end else begin
            compare_resp("resp", resp_q[0], exp);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reply_to_request();
        int e0;
        e0 = errors;
        out_q.delete();
        send_frame(make_in_frame(ARP_OPER_REQUEST, ETH_TYPE_ARP, peer_a_mac, peer_a_ip,
                                 cfg.local_ip));
        wait_frames(1, HS_TIMEOUT, "reply frame");
        if (out_q.size() > 0) begin
            compare_frame("out_frame", out_q[0], make_reply_exp(peer_a_mac, peer_a_ip));
        end
        out_q.delete();
        // another target, then a frame that is not ARP at all
        send_frame(make_in_frame(ARP_OPER_REQUEST, ETH_TYPE_ARP, peer_a_mac, peer_a_ip,
                                 32'hc0_a8_01_77));
        send_frame(make_in_frame(ARP_OPER_REQUEST, 16'h0800, peer_a_mac, peer_a_ip,
                                 cfg.local_ip));
        idle(QUIET_CYCLES);
        compare_count("out frame count", out_q.size(), 0);
        finish_test("reply to request", e0);
    endtask

    task automatic test_cache_hit();
        int e0;
        e0 = errors;
        out_q.delete();
        lookup_check(peer_a_ip, RESP_TIMEOUT, '{error: 1'b0, mac: peer_a_mac});
        idle(QUIET_CYCLES);
        compare_count("out frame count", out_q.size(), 0);
        finish_test("cache hit", e0);
    endtask

    task automatic test_broadcast();
        int e0;
        e0 = errors;
        lookup_check(32'hffff_ffff, RESP_TIMEOUT, '{error: 1'b0, mac: 48'hffff_ffff_ffff});
        lookup_check(cfg.local_ip | ~cfg.subnet_mask, RESP_TIMEOUT,
                     '{error: 1'b0, mac: 48'hffff_ffff_ffff});
        finish_test("broadcast", e0);
    endtask

    task automatic test_gateway();
        int   e0;
        mac_t gw_mac;
        ip_t  unused_ip;
        e0 = errors;
        draw_peer(gw_mac, unused_ip);
        out_q.delete();
        // gateway answers us, nothing goes back out
        send_frame(make_in_frame(ARP_OPER_REPLY, ETH_TYPE_ARP, gw_mac, cfg.gateway_ip,
                                 cfg.local_ip));
        lookup_check(32'h08_08_08_08, RESP_TIMEOUT, '{error: 1'b0, mac: gw_mac});
        compare_count("out frame count", out_q.size(), 0);
        finish_test("gateway", e0);
    endtask

    task automatic test_miss_retries();
        int e0;
        int i;
        e0 = errors;
        clear_cache = 1'b1;
        @(negedge clk);
        clear_cache = 1'b0;
        out_q.delete();
        lookup_check(peer_a_ip, RESOLVE_TIMEOUT, '{error: 1'b1, mac: 48'h0});
        compare_count("request frame count", out_q.size(), RETRY_COUNT);
        for (i = 0; i < out_q.size(); i++) begin
            compare_frame("out_frame", out_q[i], make_request_exp(peer_a_ip));
        end
        finish_test("miss and retries", e0);
    endtask

    task automatic test_backpressure();
        int         e0;
        int         i;
        mac_t       b_mac;
        ip_t        b_ip;
        mac_t       c_mac;
        ip_t        c_ip;
        arp_frame_t held;
        e0 = errors;
        draw_peer(b_mac, b_ip);
        draw_peer(c_mac, c_ip);
        out_q.delete();
        out_ready = 1'b0;
        send_frame(make_in_frame(ARP_OPER_REQUEST, ETH_TYPE_ARP, b_mac, b_ip, cfg.local_ip));
        held = out_frame;
        compare_frame("out_frame", held, make_reply_exp(b_mac, b_ip));
        // second request queues behind the stalled reply
        in_frame = make_in_frame(ARP_OPER_REQUEST, ETH_TYPE_ARP, c_mac, c_ip, cfg.local_ip);
        in_valid = 1'b1;
        for (i = 0; i < 8; i++) begin
            #1;
            compare_bit("in_ready", in_ready, 1'b0);
            compare_bit("out_valid", out_valid, 1'b1);
            compare_frame("out_frame", out_frame, held);
            @(negedge clk);
        end
        out_ready = 1'b1;
        send_frame(make_in_frame(ARP_OPER_REQUEST, ETH_TYPE_ARP, c_mac, c_ip, cfg.local_ip));
        wait_frames(2, HS_TIMEOUT, "both reply frames");
        if (out_q.size() >= 2) begin
            compare_frame("out_frame", out_q[0], make_reply_exp(b_mac, b_ip));
            compare_frame("out_frame", out_q[1], make_reply_exp(c_mac, c_ip));
        end
        finish_test("back-pressure", e0);
    endtask

    initial begin
        int n;
        in_frame    = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b1;
        req_ip      = '0;
        req_valid   = 1'b0;
        resp_ready  = 1'b1;
        clear_cache = 1'b0;
        cfg.local_mac   = 48'h02_00_00_00_00_01;
        cfg.local_ip    = 32'hc0_a8_01_0a;
        cfg.gateway_ip  = 32'hc0_a8_01_01;
        cfg.subnet_mask = 32'hffff_ff00;
        rng_state    = 32'he9f6;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        // reset is sampled just after a falling edge, where it has settled
        n = 0;
        #1;
        while (rst !== 1'b0 && n < RESET_TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (rst !== 1'b0) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            errors++;
        end
        @(negedge clk);

        draw_peer(peer_a_mac, peer_a_ip);
        test_reply_to_request();
        test_cache_hit();
        test_broadcast();
        test_gateway();
        test_miss_retries();
        test_backpressure();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: flist.f
arp_proto_pkg.sv
arp_engine_pkg.sv
arp_hold_reg.sv
arp_cache.sv
arp_rx_decode.sv
arp_resolver.sv
arp_tx_build.sv
arp_top.sv
tb_clk_gen.sv
tb_arp.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the ARP engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_arp -f flist.f -o tb_arp_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_arp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    exit 0
fi
exit 1
